//--- logic/spongent_pkg.sv
// ##################################################
// Sizes, constants and types for SPONGENT-88/80/8
// Only the 88/80/8 variant is covered, so the round
// counter LFSR is fixed at 6 bits
// ##################################################
`default_nettype none

package spongent_pkg;

    // ##################################################
    // Sponge geometry
    // ##################################################
    localparam int state_width    = 88;  // Permutation width N
    localparam int rate_width     = 8;   // Rate r, one message byte per block
    localparam int capacity_width = 80;  // Capacity c
    localparam int round_count    = 45;  // Rounds per permutation R
    localparam int squeeze_blocks = 11;  // Rate blocks that make up the digest
    localparam int nibble_count   = state_width / 4;  // S-boxes per round

    localparam int round_idx_width = $clog2(round_count);
    localparam int sq_count_width  = $clog2(squeeze_blocks);

    // ##################################################
    // Round counter LFSR
    // ##################################################
    localparam int lcounter_width = 6;
    localparam logic [lcounter_width-1:0] lcounter_init     = 6'h05;  // Start of every permutation
    localparam logic [lcounter_width:0]   lcounter_feedback = 7'h61;  // x^6 + x^5 + 1

    // 4-bit S-box, entry i sits at bits [4i+3:4i]
    localparam logic [63:0] sbox_table = 64'h63C9_58A7_F412_0BDE;

    // Block appended after the last message byte
    localparam logic [rate_width-1:0] pad_byte = 8'h80;

    // ##################################################
    // Types
    // ##################################################
    typedef struct packed {
        logic [rate_width-1:0] data;  // Rate block XORed into the state
        logic                  last;  // Set only on the pad block of a message
    } block_t;

    typedef logic [state_width-1:0] digest_t;  // First squeezed byte in the top bits

    typedef enum logic [1:0] {
        idle,          // Waiting for a block, ready is high
        absorb_perm,   // Permutation after absorbing a block
        squeeze_perm   // Emitting digest bytes with permutations in between
    } sponge_state_e;

endpackage : spongent_pkg

`default_nettype wire

//--- logic/spongent_round.sv
// ##################################################
// One combinational SPONGENT-88 round
// Counter injection, S-box layer, bit permutation
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module spongent_round
    import spongent_pkg::*;
(
    input  logic [state_width-1:0]    state_in,
    input  logic [lcounter_width-1:0] lcounter,
    output logic [state_width-1:0]    state_out
);

    logic [lcounter_width-1:0] lcounter_rev;  // Counter with bit order swapped
    logic [state_width-1:0]    ctr_state;     // After counter injection
    logic [state_width-1:0]    sbox_state;    // After the S-box layer

    always_comb begin
        for (int k = 0; k < lcounter_width; k++) begin
            lcounter_rev[k] = lcounter[lcounter_width-1-k];
        end
    end

    // Counter into the low end, reversed counter into the high end
    assign ctr_state = state_in ^ {lcounter_rev,
                                   {(state_width - 2 * lcounter_width){1'b0}},
                                   lcounter};

    // ##################################################
    // S-box layer over all nibbles
    // ##################################################
    for (genvar n = 0; n < nibble_count; n++) begin : g_sbox
        assign sbox_state[4*n +: 4] = sbox_table[{ctr_state[4*n +: 4], 2'b00} +: 4];
    end

    // ##################################################
    // Bit permutation
    // ##################################################
    // Bit j moves to j*N/4 mod (N-1), the top bit stays put
    for (genvar j = 0; j < state_width - 1; j++) begin : g_perm
        assign state_out[(j * nibble_count) % (state_width - 1)] = sbox_state[j];
    end

    assign state_out[state_width-1] = sbox_state[state_width-1];

endmodule : spongent_round

`default_nettype wire

//--- logic/spongent_pad.sv
// ##################################################
// Padding stage in front of the sponge core
// No back-pressure, a byte that cannot be taken is
// dropped and flagged on overrun a cycle later
// Empty messages are not supported
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module spongent_pad
    import spongent_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  byte_valid,
    input  logic [rate_width-1:0] byte_data,
    input  logic                  byte_last,
    input  logic                  ready,
    output logic                  blk_valid,
    output block_t                blk,
    output logic                  overrun
);

    logic pad_pending;  // The pad block of the current message is still owed
    logic accept;       // Byte goes through to the core this cycle
    logic pad_issue;    // Pad block goes to the core this cycle

    // A byte must not overtake the pad block of the previous message
    assign accept    = byte_valid && ready && !pad_pending;
    assign pad_issue = pad_pending && ready;

    // Bytes pass straight through in the strobe cycle
    assign blk_valid = accept || pad_issue;

    always_comb begin
        if (pad_pending) begin
            blk.data = pad_byte;
            blk.last = 1'b1;
        end else begin
            blk.data = byte_data;
            blk.last = 1'b0;
        end
    end

    // ##################################################
    // Pad slot and overrun flag
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pad_pending <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            overrun <= byte_valid && !accept;  // Any refused byte is lost
            if (pad_issue) begin
                pad_pending <= 1'b0;
            end else if (accept && byte_last) begin
                pad_pending <= 1'b1;  // Goes out once the core is idle again
            end
        end
    end

endmodule : spongent_pad

`default_nettype wire

//--- logic/spongent_sponge.sv
// ##################################################
// Iterative sponge core, one round per clock
// Takes a block only while ready is high, one
// message at a time; the state is cleared after
// the last digest byte has gone out
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module spongent_sponge
    import spongent_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  blk_valid,
    input  block_t                blk,
    output logic                  ready,
    output logic                  sq_valid,
    output logic [rate_width-1:0] sq_byte,
    output logic                  sq_last
);

    sponge_state_e              fsm;
    logic [state_width-1:0]     state;
    logic [state_width-1:0]     round_out;
    logic [lcounter_width-1:0]  lfsr;
    logic [lcounter_width-1:0]  lfsr_next;
    logic [round_idx_width-1:0] round_idx;  // Rounds done in this permutation
    logic [sq_count_width-1:0]  sq_count;   // Digest bytes already emitted
    logic                       pad_seen;   // Block being permuted was the pad block
    logic                       emit;       // Output cycle between squeeze permutations
    logic                       last_round;
    logic                       last_byte;

    spongent_round round_inst (
        .state_in  (state),
        .lcounter  (lfsr),
        .state_out (round_out)
    );

    // Fibonacci LFSR, taps taken from the feedback coefficients
    assign lfsr_next  = {lfsr[lcounter_width-2:0],
                         ^(lfsr & lcounter_feedback[lcounter_width:1])};

    assign last_round = round_idx == round_idx_width'(round_count - 1);
    assign last_byte  = sq_count == sq_count_width'(squeeze_blocks - 1);

    assign ready    = fsm == idle;
    assign sq_valid = (fsm == squeeze_perm) && emit;
    assign sq_byte  = state[rate_width-1:0];  // Rate bits of the state
    assign sq_last  = sq_valid && last_byte;

    // ##################################################
    // Absorb, permute and squeeze sequencing
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsm       <= idle;
            state     <= '0;
            lfsr      <= lcounter_init;
            round_idx <= '0;
            sq_count  <= '0;
            pad_seen  <= 1'b0;
            emit      <= 1'b0;
        end else begin
            case (fsm)
                idle: begin
                    if (blk_valid) begin
                        state <= {state[state_width-1 -: capacity_width],
                                  state[rate_width-1:0] ^ blk.data};  // Absorb into rate
                        pad_seen  <= blk.last;
                        lfsr      <= lcounter_init;
                        round_idx <= '0;
                        fsm       <= absorb_perm;
                    end
                end
                absorb_perm: begin
                    state     <= round_out;
                    lfsr      <= lfsr_next;
                    round_idx <= round_idx + 1'b1;
                    if (last_round) begin
                        if (pad_seen) begin
                            fsm      <= squeeze_perm;  // First byte needs no extra permutation
                            emit     <= 1'b1;
                            sq_count <= '0;
                        end else begin
                            fsm <= idle;
                        end
                    end
                end
                squeeze_perm: begin
                    if (emit) begin
                        emit      <= 1'b0;
                        sq_count  <= sq_count + 1'b1;
                        lfsr      <= lcounter_init;
                        round_idx <= '0;
                        if (last_byte) begin
                            state <= '0;  // Next message starts from the zero state
                            fsm   <= idle;
                        end
                    end else begin
                        state     <= round_out;
                        lfsr      <= lfsr_next;
                        round_idx <= round_idx + 1'b1;
                        emit      <= last_round;
                    end
                end
                default: fsm <= idle;
            endcase
        end
    end

endmodule : spongent_sponge

`default_nettype wire

//--- logic/spongent_squeeze.sv
// ##################################################
// Digest collector behind the sponge core
// Expects exactly 11 bytes per digest, the first one
// ends up in the top bits; no back-pressure
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module spongent_squeeze
    import spongent_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sq_valid,
    input  logic [rate_width-1:0] sq_byte,
    input  logic                  sq_last,
    output logic                  digest_valid,
    output digest_t               digest
);

    digest_t acc;        // Bytes collected so far
    digest_t acc_shift;  // Accumulator with the incoming byte shifted in

    assign acc_shift = {acc[state_width-rate_width-1:0], sq_byte};

    // Shift register and held digest
    always_ff @(posedge clk) begin
        if (sq_valid) begin
            acc <= acc_shift;
        end
        if (sq_valid && sq_last) begin
            digest <= acc_shift;  // Held until the next digest lands
        end
    end

    // Strobe trails the eleventh byte by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digest_valid <= 1'b0;
        end else begin
            digest_valid <= sq_valid && sq_last;
        end
    end

endmodule : spongent_squeeze

`default_nettype wire

//--- logic/spongent_hash.sv
// ##################################################
// SPONGENT-88/80/8 hash engine top level
// One byte per strobe, no back-pressure; watch busy
// and overrun. One message in the sponge at a time
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module spongent_hash
    import spongent_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  byte_valid,
    input  logic [rate_width-1:0] byte_data,
    input  logic                  byte_last,
    output logic                  busy,
    output logic                  overrun,
    output logic                  digest_valid,
    output digest_t               digest
);

    logic                  ready;
    logic                  blk_valid;
    block_t                blk;
    logic                  sq_valid;
    logic [rate_width-1:0] sq_byte;
    logic                  sq_last;

    assign busy = ~ready;  // Core is not idle

    spongent_pad pad_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_last  (byte_last),
        .ready      (ready),
        .blk_valid  (blk_valid),
        .blk        (blk),
        .overrun    (overrun)
    );

    spongent_sponge sponge_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_valid (blk_valid),
        .blk       (blk),
        .ready     (ready),
        .sq_valid  (sq_valid),
        .sq_byte   (sq_byte),
        .sq_last   (sq_last)
    );

    spongent_squeeze squeeze_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .sq_valid     (sq_valid),
        .sq_byte      (sq_byte),
        .sq_last      (sq_last),
        .digest_valid (digest_valid),
        .digest       (digest)
    );

endmodule : spongent_hash

`default_nettype wire

//--- test/spongent_model.svh
// ##################################################
// Golden SPONGENT-88/80/8 model and stimulus LFSR
// Bit 0 of the state is the first rate bit; needs
// spongent_pkg imported by the including module
// ##################################################
`ifndef spongent_model_svh
`define spongent_model_svh

typedef logic [7:0] msg_q_t[$];

// SPONGENT S-box, indexed by the input nibble
localparam logic [3:0] sbox_values [16] = '{4'hE, 4'hD, 4'hB, 4'h0, 4'h2, 4'h1, 4'h4, 4'hF,
                                             4'h7, 4'hA, 4'h8, 4'h5, 4'h9, 4'hC, 4'h3, 4'h6};

function automatic logic [lcounter_width-1:0] counter_step(
    input logic [lcounter_width-1:0] c
);
    logic fb;
    fb = 1'b0;
    for (int k = 0; k < lcounter_width; k++) begin
        if (lcounter_feedback[k+1]) begin
            fb ^= c[k];  // Tap k feeds the new low bit
        end
    end
    return {c[lcounter_width-2:0], fb};
endfunction

function automatic logic [state_width-1:0] apply_round(
    input logic [state_width-1:0]    s,
    input logic [lcounter_width-1:0] c
);
    logic [state_width-1:0] t;
    logic [state_width-1:0] p;
    t = s;
    for (int k = 0; k < lcounter_width; k++) begin
        t[k]               ^= c[k];  // Counter at the bottom
        t[state_width-1-k] ^= c[k];  // Mirrored counter at the top
    end
    for (int n = 0; n < state_width / 4; n++) begin
        t[4*n +: 4] = sbox_values[t[4*n +: 4]];
    end
    p = '0;
    for (int j = 0; j < state_width - 1; j++) begin
        p[(j * (state_width / 4)) % (state_width - 1)] = t[j];
    end
    p[state_width-1] = t[state_width-1];
    return p;
endfunction

function automatic logic [state_width-1:0] run_permutation(input logic [state_width-1:0] s);
    logic [lcounter_width-1:0] c;
    c = lcounter_init;  // Counter restarts for every permutation
    for (int r = 0; r < round_count; r++) begin
        s = apply_round(s, c);
        c = counter_step(c);
    end
    return s;
endfunction

function automatic digest_t expected_digest(input msg_q_t msg);
    logic [state_width-1:0] s;
    digest_t                d;
    s = '0;
    d = '0;
    foreach (msg[i]) begin
        s[rate_width-1:0] ^= msg[i];
        s = run_permutation(s);
    end
    s[rate_width-1:0] ^= pad_byte;
    s = run_permutation(s);
    for (int b = 0; b < squeeze_blocks; b++) begin
        d = {d[state_width-rate_width-1:0], s[rate_width-1:0]};  // First byte ends on top
        if (b < squeeze_blocks - 1) begin
            s = run_permutation(s);
        end
    end
    return d;
endfunction

// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
function automatic logic [31:0] next_rand_state(input logic [31:0] r);
    return {r[30:0], r[31] ^ r[21] ^ r[1] ^ r[0]};
endfunction

`endif

//--- test/spongent_hash_tb.sv
// ##################################################
// Testbench for the SPONGENT-88/80/8 hash engine
// Messages come from a fixed table, one stray byte
// is strobed into two of them while the core is busy
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module spongent_hash_tb
    import spongent_pkg::*;
();

    typedef struct packed {
        int           len;          // Message length in bytes, 1 to 16
        int           stray_after;  // Byte index followed by a stray strobe, -1 for none
        logic [127:0] data;         // Byte i sits at [8i +: 8]
    } msg_entry_t;

    localparam int         msg_count  = 7;
    localparam logic [7:0] stray_byte = 8'hA5;
    // Last data perm, pad perm and ten squeeze perms, each with one extra edge
    localparam int         latency    = (round_count + 1) * (squeeze_blocks + 1);

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  byte_valid;
    logic [rate_width-1:0] byte_data;
    logic                  byte_last;
    logic                  busy;
    logic                  overrun;
    logic                  digest_valid;
    digest_t               digest;

    msg_entry_t msg_table [msg_count];
    digest_t    expected  [msg_count];
    digest_t    observed  [msg_count];
    int         cycle_count;
    int         timeout_limit;
    int         accept_cycle;    // Cycle in which the last byte was taken
    int         digest_pulses;
    int         overrun_pulses;
    int         checks_done;
    int         errors_seen;

    `include "spongent_model.svh"

    spongent_hash spongent_hash_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .byte_last    (byte_last),
        .busy         (busy),
        .overrun      (overrun),
        .digest_valid (digest_valid),
        .digest       (digest)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Strobes are counted mid cycle where they are stable
    always @(negedge clk) begin
        if (rst_n && digest_valid) begin
            digest_pulses <= digest_pulses + 1;
        end
        if (rst_n && overrun) begin
            overrun_pulses <= overrun_pulses + 1;
        end
    end

    // ##################################################
    // Compare tasks
    // ##################################################
    task automatic check_digest(input string name, input digest_t got, input digest_t exp);
        checks_done++;
        if (got !== exp) begin
            errors_seen++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks_done++;
        if (got !== exp) begin
            errors_seen++;
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks_done++;
        if (got != exp) begin
            errors_seen++;
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ##################################################
    // Stimulus
    // ##################################################
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_table();
        logic [31:0]  rng;
        logic [127:0] rand_data;
        rng       = 32'hba21_b7bb;
        rand_data = '0;
        for (int i = 0; i < 128; i++) begin
            rng       = next_rand_state(rng);
            rand_data = {rand_data[126:0], rng[0]};  // One step per bit
        end
        msg_table[0] = '{len: 1, stray_after: -1, data: 128'h61};
        msg_table[1] = '{len: 3, stray_after: -1, data: 128'h636261};
        msg_table[2] = '{len: 8, stray_after: -1, data: 128'hefcdab8967452301};
        msg_table[3] = msg_table[2];  // Same message again right behind it
        msg_table[4] = '{len: 16, stray_after: -1, data: rand_data};
        msg_table[5] = '{len: 4, stray_after: 1, data: 128'hefbeadde};
        msg_table[6] = '{len: 2, stray_after: 1, data: 128'hc35a};  // Stray behind the last byte
    endtask

    task automatic send_byte(input logic [rate_width-1:0] data, input logic last,
                             input logic stray);
        while (busy) begin
            next_cycle();
        end
        byte_valid = 1'b1;
        byte_data  = data;
        byte_last  = last;
        next_cycle();
        byte_valid   = 1'b0;
        byte_last    = 1'b0;
        accept_cycle = cycle_count;
        for (int i = 0; i < round_count; i++) begin
            check_bit("busy", busy, 1'b1);
            if (stray && i == 1) begin
                byte_valid = 1'b1;  // Core is mid permutation so this byte is lost
                byte_data  = stray_byte;
                next_cycle();
                byte_valid = 1'b0;
                check_bit("overrun", overrun, 1'b1);
            end else begin
                next_cycle();
            end
        end
        check_bit("busy", busy, 1'b0);
    endtask

    initial begin : main_sequence
        msg_q_t msg;
        int     errors_before;
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = '0;
        byte_last  = 1'b0;
        load_table();
        timeout_limit = 16;
        for (int m = 0; m < msg_count; m++) begin
            timeout_limit += msg_table[m].len * 50 + 600;
            msg.delete();
            for (int i = 0; i < msg_table[m].len; i++) begin
                msg.push_back(msg_table[m].data[8*i +: 8]);
            end
            expected[m] = expected_digest(msg);
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errors_before = errors_seen;
        repeat (3) begin
            check_bit("busy", busy, 1'b0);
            check_bit("overrun", overrun, 1'b0);
            check_bit("digest_valid", digest_valid, 1'b0);
            next_cycle();
        end
        $display("reset: %s", errors_seen == errors_before ? "ok" : "errors");

        for (int m = 0; m < msg_count; m++) begin
            errors_before = errors_seen;
            for (int i = 0; i < msg_table[m].len; i++) begin
                send_byte(msg_table[m].data[8*i +: 8], i == msg_table[m].len - 1,
                          i == msg_table[m].stray_after);
            end
            while (!digest_valid) begin
                next_cycle();
            end
            if (msg_table[m].stray_after < 0) begin
                check_count("latency", cycle_count - accept_cycle, latency);
            end
            check_digest("digest", digest, expected[m]);
            observed[m] = digest;
            next_cycle();
            check_bit("digest_valid", digest_valid, 1'b0);
            check_count("digest pulses", digest_pulses, m + 1);
            $display("message %0d: %0d bytes, digest %h, %s", m, msg_table[m].len,
                     observed[m], errors_seen == errors_before ? "ok" : "errors");
        end

        check_digest("repeated digest", observed[3], observed[2]);
        check_count("overrun pulses", overrun_pulses, 2);
        $display("checks %0d, errors %0d", checks_done, errors_seen);
        if (errors_seen == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : spongent_hash_tb

`default_nettype wire

//--- spongent_hash.f
+incdir+test
logic/spongent_pkg.sv
logic/spongent_round.sv
logic/spongent_pad.sv
logic/spongent_sponge.sv
logic/spongent_squeeze.sv
logic/spongent_hash.sv
test/spongent_hash_tb.sv

//--- Makefile
# Verilator build and run of the SPONGENT-88 hash testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f spongent_hash.f \
		--top-module spongent_hash_tb -Mdir obj_dir -o spongent_hash_sim
	./obj_dir/spongent_hash_sim > $(LOG)
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
